// File: hdl/bus_pkg.sv
/*
  Shared bus types. Host order sets arbitration priority, index 0 highest.
  The bus is fixed at 32-bit address and data.
*/
package bus_pkg;

  localparam int unsigned NrHosts   = 3;
  localparam int unsigned NrDevices = 2;

  // Hosts in decreasing priority
  typedef enum logic [1:0] {
    TestUtilHost,
    CoreData,
    CoreInstr
  } bus_host_e;

  typedef enum logic {
    Ram,
    TestUtilDevice
  } bus_device_e;

  // Request fields must stay stable from req until gnt
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  // Response arrives exactly one cycle after the grant
  typedef struct packed {
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } bus_rsp_t;

endpackage

// File: hdl/mem_map_pkg.sv
/*
  Address map. Each window is matched as (addr & mask) == base,
  so window sizes must be powers of two.
*/
package mem_map_pkg;

  // 64 kB of RAM
  localparam int unsigned RamSizeWords = 64 * 1024 / 4;
  localparam int unsigned RamIdxWidth  = $clog2(RamSizeWords);

  localparam logic [31:0] RamBase      = 32'h0000_0000;
  localparam logic [31:0] RamMask      = ~32'(RamSizeWords * 4 - 1);
  localparam logic [31:0] TestUtilBase = 32'h0002_0000;
  localparam logic [31:0] TestUtilMask = ~32'h0000_03FF;

  // Register offsets inside the 1 kB test utility window
  typedef enum logic [9:0] {
    SigBegin = 10'h000,
    SigEnd   = 10'h004,
    Halt     = 10'h008
  } test_util_reg_e;

endpackage

// File: hdl/bus_arbiter.sv
/*
  Fixed priority arbiter, lowest host index wins. Grants are combinational.
  A host is not granted in the cycle its previous response returns.
*/
module bus_arbiter import bus_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  bus_req_t  host_req_i [NrHosts],
  output logic      host_gnt_o [NrHosts],
  output bus_req_t  sel_req_o,
  output bus_host_e sel_host_o
);

  // One flag per host, set for the cycle its response is in flight
  logic [NrHosts-1:0] busy_q;
  logic               found;

  always_comb begin
    found      = 1'b0;
    sel_req_o  = '0;
    sel_host_o = TestUtilHost;
    for (int i = 0; i < NrHosts; i++) begin
      host_gnt_o[i] = 1'b0;
    end
    for (int i = 0; i < NrHosts; i++) begin
      if (!found && host_req_i[i].req && !busy_q[i]) begin
        found         = 1'b1;
        host_gnt_o[i] = 1'b1;
        sel_req_o     = host_req_i[i];
        sel_host_o    = bus_host_e'(i[1:0]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= '0;
    end else begin
      for (int i = 0; i < NrHosts; i++) begin
        busy_q[i] <= host_gnt_o[i];
      end
    end
  end

endmodule

// File: hdl/bus_router.sv
/*
  Address decode and response steering. Responses are expected one cycle
  after a request. Unmapped addresses answer with err and zero rdata.
*/
module bus_router import bus_pkg::*, mem_map_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  bus_req_t    sel_req_i,
  input  bus_host_e   sel_host_i,
  output bus_req_t    dev_req_o  [NrDevices],
  input  bus_rsp_t    dev_rsp_i  [NrDevices],
  output bus_rsp_t    host_rsp_o [NrHosts]
);

  logic        hit_ram;
  logic        hit_tu;

  // Steering state for the response in flight
  logic        pending_q;
  logic        miss_q;
  bus_host_e   host_q;
  bus_device_e dev_q;

  assign hit_ram = (sel_req_i.addr & RamMask) == RamBase;
  assign hit_tu  = (sel_req_i.addr & TestUtilMask) == TestUtilBase;

  always_comb begin
    dev_req_o[Ram]                = sel_req_i;
    dev_req_o[Ram].req            = sel_req_i.req && hit_ram;
    dev_req_o[TestUtilDevice]     = sel_req_i;
    dev_req_o[TestUtilDevice].req = sel_req_i.req && hit_tu && !hit_ram;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
      miss_q    <= 1'b0;
      host_q    <= TestUtilHost;
      dev_q     <= Ram;
    end else begin
      pending_q <= sel_req_i.req;
      miss_q    <= sel_req_i.req && !hit_ram && !hit_tu;
      host_q    <= sel_host_i;
      dev_q     <= hit_ram ? Ram : TestUtilDevice;
    end
  end

  // Only the host granted last cycle sees a response
  always_comb begin
    for (int i = 0; i < NrHosts; i++) begin
      host_rsp_o[i] = '0;
      if (pending_q && host_q == bus_host_e'(i[1:0])) begin
        if (miss_q) begin
          host_rsp_o[i].rvalid = 1'b1;
          host_rsp_o[i].err    = 1'b1;
        end else begin
          host_rsp_o[i] = dev_rsp_i[dev_q];
        end
      end
    end
  end

endmodule

// File: hdl/ram_1p.sv
/*
  Single port word RAM, no init. Address bits above the window are ignored.
  Every access answers rvalid one cycle later; rdata only on reads.
*/
module ram_1p import bus_pkg::*, mem_map_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  logic [31:0]            mem [RamSizeWords];
  logic [RamIdxWidth-1:0] idx;
  logic                   rvalid_q;
  logic [31:0]            rdata_q;

  // Word index from a byte address
  assign idx = req_i.addr[RamIdxWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.err    = 1'b0;
  assign rsp_o.rdata  = rdata_q;

endmodule

// File: hdl/test_util.sv
/*
  Signature dump engine. Region end is exclusive and words are read in 4-byte
  steps; partial writes and unknown offsets answer err. Dump runs once per reset.
*/
module test_util import bus_pkg::*, mem_map_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  bus_req_t    dev_req_i,
  output bus_rsp_t    dev_rsp_o,
  output bus_req_t    host_req_o,
  input  logic        host_gnt_i,
  input  bus_rsp_t    host_rsp_i,
  output logic [31:0] dump_o,
  output logic        dump_valid_o,
  input  logic        dump_ready_i,
  output logic        halted_o
);

  typedef enum logic [2:0] {Idle, Read, Wait, Emit, Done} dump_state_e;

  dump_state_e state_q;
  logic [31:0] sig_begin_q;
  logic [31:0] sig_end_q;
  logic [31:0] ptr_q;
  logic [31:0] word_q;

  logic        reg_err;
  logic [31:0] reg_rdata;
  logic        reg_wr;
  logic        rsp_valid_q;
  logic        rsp_err_q;
  logic [31:0] rsp_rdata_q;

  // Register decode
  always_comb begin
    reg_err   = 1'b0;
    reg_rdata = '0;
    case (dev_req_i.addr[9:0])
      SigBegin: reg_rdata = sig_begin_q;
      SigEnd:   reg_rdata = sig_end_q;
      Halt:     reg_rdata = '0;
      default:  reg_err   = 1'b1;
    endcase
    // Only full word writes are accepted
    if (dev_req_i.we && dev_req_i.be != 4'hF) begin
      reg_err = 1'b1;
    end
  end

  assign reg_wr = dev_req_i.req && dev_req_i.we && !reg_err;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sig_begin_q <= '0;
      sig_end_q   <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= dev_req_i.req;
      if (reg_wr && dev_req_i.addr[9:0] == SigBegin) begin
        sig_begin_q <= dev_req_i.wdata;
      end
      if (reg_wr && dev_req_i.addr[9:0] == SigEnd) begin
        sig_end_q <= dev_req_i.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dev_req_i.req) begin
      rsp_err_q   <= reg_err;
      rsp_rdata_q <= dev_req_i.we ? '0 : reg_rdata;
    end
  end

  assign dev_rsp_o.rvalid = rsp_valid_q;
  assign dev_rsp_o.err    = rsp_err_q;
  assign dev_rsp_o.rdata  = rsp_rdata_q;

  // Dump FSM, halt writes outside Idle have no effect
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Idle;
    end else begin
      case (state_q)
        Idle: begin
          if (reg_wr && dev_req_i.addr[9:0] == Halt) begin
            state_q <= (sig_begin_q >= sig_end_q) ? Done : Read;
          end
        end
        Read:    if (host_gnt_i) state_q <= Wait;
        Wait:    if (host_rsp_i.rvalid) state_q <= Emit;
        Emit:    if (dump_ready_i) state_q <= (ptr_q >= sig_end_q) ? Done : Read;
        default: state_q <= Done;
      endcase
    end
  end

  // Pointer is already advanced when the word is on the stream
  always_ff @(posedge clk_i) begin
    if (state_q == Idle) begin
      ptr_q <= sig_begin_q;
    end else if (state_q == Wait && host_rsp_i.rvalid) begin
      ptr_q  <= ptr_q + 32'd4;
      word_q <= host_rsp_i.rdata;
    end
  end

  assign host_req_o.req   = (state_q == Read);
  assign host_req_o.we    = 1'b0;
  assign host_req_o.be    = 4'hF;
  assign host_req_o.addr  = ptr_q;
  assign host_req_o.wdata = '0;

  assign dump_o       = word_q;
  assign dump_valid_o = (state_q == Emit);
  assign halted_o     = (state_q == Done);

endmodule

// File: hdl/compliance_top.sv
/*
  Compliance bus fabric. Two external hosts plus the test utility share one
  bus to RAM and the test utility registers.
*/
module compliance_top import bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  bus_req_t    data_req_i,
  input  bus_req_t    instr_req_i,
  output logic        data_gnt_o,
  output logic        instr_gnt_o,
  output bus_rsp_t    data_rsp_o,
  output bus_rsp_t    instr_rsp_o,
  output logic [31:0] dump_o,
  output logic        dump_valid_o,
  input  logic        dump_ready_i,
  output logic        halted_o
);

  bus_req_t  host_req [NrHosts];
  logic      host_gnt [NrHosts];
  bus_rsp_t  host_rsp [NrHosts];
  bus_req_t  sel_req;
  bus_host_e sel_host;
  bus_req_t  dev_req  [NrDevices];
  bus_rsp_t  dev_rsp  [NrDevices];

  assign host_req[CoreData]  = data_req_i;
  assign host_req[CoreInstr] = instr_req_i;
  assign data_gnt_o          = host_gnt[CoreData];
  assign instr_gnt_o         = host_gnt[CoreInstr];
  assign data_rsp_o          = host_rsp[CoreData];
  assign instr_rsp_o         = host_rsp[CoreInstr];

  bus_arbiter u_arbiter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .host_req_i (host_req),
    .host_gnt_o (host_gnt),
    .sel_req_o  (sel_req),
    .sel_host_o (sel_host)
  );

  bus_router u_router (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .sel_req_i  (sel_req),
    .sel_host_i (sel_host),
    .dev_req_o  (dev_req),
    .dev_rsp_i  (dev_rsp),
    .host_rsp_o (host_rsp)
  );

  ram_1p u_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (dev_req[Ram]),
    .rsp_o   (dev_rsp[Ram])
  );

  // Test utility is both a device and the top priority host
  test_util u_test_util (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .dev_req_i    (dev_req[TestUtilDevice]),
    .dev_rsp_o    (dev_rsp[TestUtilDevice]),
    .host_req_o   (host_req[TestUtilHost]),
    .host_gnt_i   (host_gnt[TestUtilHost]),
    .host_rsp_i   (host_rsp[TestUtilHost]),
    .dump_o       (dump_o),
    .dump_valid_o (dump_valid_o),
    .dump_ready_i (dump_ready_i),
    .halted_o     (halted_o)
  );

endmodule

// File: dv/compliance_assertions.sv
/*
  Bus protocol checks, bound into the top level so grants and responses are
  both visible. Checks are off while reset is low.
*/
module compliance_assertions import bus_pkg::*; (
  input logic     clk_i,
  input logic     rst_n_i,
  input bus_req_t host_req_i [NrHosts],
  input logic     host_gnt_i [NrHosts],
  input bus_rsp_t host_rsp_i [NrHosts]
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [NrHosts-1:0] gnt_vec;
  logic [NrHosts-1:0] req_vec;
  logic [NrHosts-1:0] rvalid_vec;
  int                 nr_failures = 0;

  always_comb begin
    for (int i = 0; i < NrHosts; i++) begin
      gnt_vec[i]    = host_gnt_i[i];
      req_vec[i]    = host_req_i[i].req;
      rvalid_vec[i] = host_rsp_i[i].rvalid;
    end
  end

  a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_vec))
    else begin
      $error("more than one grant in a cycle");
      nr_failures++;
    end

  a_grant_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gnt_vec & ~req_vec) == '0)
    else begin
      $error("grant without a request");
      nr_failures++;
    end

  // Response goes only to the granted host one cycle later
  a_rvalid_after_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_vec != '0 |=> rvalid_vec == $past(gnt_vec))
    else begin
      $error("rvalid missing one cycle after grant");
      nr_failures++;
    end

endmodule

bind compliance_top compliance_assertions u_assertions (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .host_req_i (host_req),
  .host_gnt_i (host_gnt),
  .host_rsp_i (host_rsp)
);

// File: dv/tb_compliance.sv
/*
  Testbench playing the core on the data and instruction ports.
  RAM is not reset, so the model only predicts words written before.
*/
module tb_compliance import bus_pkg::*, mem_map_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          TableLen   = 16;
  localparam int          DumpWords  = 16;
  localparam int          CycleLimit = TableLen * 4 + DumpWords * 8 + 200;
  localparam logic [31:0] SigBase    = 32'h0000_1000;
  localparam logic [31:0] EmptyBase  = 32'h0000_2000;
  localparam logic [31:0] RegBegin   = 32'h0002_0000;
  localparam logic [31:0] RegEnd     = 32'h0002_0004;
  localparam logic [31:0] RegHalt    = 32'h0002_0008;

  typedef struct packed {
    bus_host_e   host;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
  } tbl_entry_t;

  // exp_rdata is only used outside the RAM window
  tbl_entry_t tbl [TableLen] = '{
    '{CoreData,  1'b1, 4'hF, 32'h0000_0100, 32'h1122_3344, 32'h0, 1'b0},
    '{CoreInstr, 1'b1, 4'h3, 32'h0000_0100, 32'hAAAA_5555, 32'h0, 1'b0},
    '{CoreData,  1'b1, 4'hF, 32'h0000_0104, 32'hDEAD_BEEF, 32'h0, 1'b0},
    '{CoreInstr, 1'b1, 4'h4, 32'h0000_0104, 32'h0077_0000, 32'h0, 1'b0},
    '{CoreData,  1'b1, 4'h8, 32'h0000_0104, 32'h9900_0000, 32'h0, 1'b0},
    '{CoreData,  1'b0, 4'hF, 32'h0000_0100, 32'h0,         32'h0, 1'b0},
    '{CoreInstr, 1'b0, 4'hF, 32'h0000_0104, 32'h0,         32'h0, 1'b0},
    '{CoreData,  1'b0, 4'hF, 32'h0004_0000, 32'h0,         32'h0, 1'b1},
    '{CoreInstr, 1'b1, 4'hF, 32'h0004_0100, 32'h1234_5678, 32'h0, 1'b1},
    '{CoreData,  1'b0, 4'hF, 32'h0000_0100, 32'h0,         32'h0, 1'b0},
    '{CoreData,  1'b1, 4'hF, 32'h0002_0000, 32'h0000_1000, 32'h0, 1'b0},
    '{CoreInstr, 1'b1, 4'hF, 32'h0002_0004, 32'h0000_1040, 32'h0, 1'b0},
    '{CoreData,  1'b0, 4'hF, 32'h0002_0000, 32'h0, 32'h0000_1000, 1'b0},
    '{CoreInstr, 1'b0, 4'hF, 32'h0002_0004, 32'h0, 32'h0000_1040, 1'b0},
    '{CoreData,  1'b0, 4'hF, 32'h0002_000C, 32'h0,         32'h0, 1'b1},
    '{CoreInstr, 1'b0, 4'hF, 32'h0002_0008, 32'h0,         32'h0, 1'b0}
  };

  logic        clk = 1'b0;
  logic        rst_n;
  bus_req_t    data_req;
  bus_req_t    instr_req;
  logic        data_gnt;
  logic        instr_gnt;
  bus_rsp_t    data_rsp;
  bus_rsp_t    instr_rsp;
  logic [31:0] dump;
  logic        dump_valid;
  logic        dump_ready;
  logic        halted;

  logic [31:0] model [RamSizeWords];
  integer      seed = 32'h72c273f2;
  int          errors = 0;
  int          tests = 0;
  int          cycles = 0;

  compliance_top u_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .data_req_i   (data_req),
    .instr_req_i  (instr_req),
    .data_gnt_o   (data_gnt),
    .instr_gnt_o  (instr_gnt),
    .data_rsp_o   (data_rsp),
    .instr_rsp_o  (instr_rsp),
    .dump_o       (dump),
    .dump_valid_o (dump_valid),
    .dump_ready_i (dump_ready),
    .halted_o     (halted)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic check_rsp(input bus_rsp_t act, input bus_rsp_t exp, input logic cmp_data,
                           input string what);
    if (act.rvalid !== exp.rvalid || act.err !== exp.err ||
        (cmp_data && act.rdata !== exp.rdata)) begin
      $display("[ERROR] %0t: %s got rvalid=%b err=%b rdata=%h, expected %b %b %h", $time,
               what, act.rvalid, act.err, act.rdata, exp.rvalid, exp.err, exp.rdata);
      errors++;
    end
  endtask

  task automatic check_dump_word(input logic [31:0] act, input logic [31:0] exp, input int idx);
    if (act !== exp) begin
      $display("[ERROR] %0t: dump word %0d is %h, expected %h", $time, idx, act, exp);
      errors++;
    end
  endtask

  task automatic check_host(input bus_host_e act, input bus_host_e exp);
    if (act !== exp) begin
      $display("[ERROR] %0t: granted %s, expected %s", $time, act.name(), exp.name());
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d error(s)", tests, name, errors - errs_before);
    end
  endtask

  function automatic void model_write(input logic [31:0] addr, input logic [3:0] be,
                                      input logic [31:0] wdata);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        model[addr[RamIdxWidth+1:2]][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endfunction

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  // One access from a core port that holds req until granted
  task automatic bus_access(input bus_host_e host, input logic we, input logic [3:0] be,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output bus_rsp_t rsp);
    bus_req_t req;
    logic     gnt;
    req.req   = 1'b1;
    req.we    = we;
    req.be    = be;
    req.addr  = addr;
    req.wdata = wdata;
    gnt       = 1'b0;
    @(posedge clk);
    #2;
    if (host == CoreData) begin
      data_req = req;
    end else begin
      instr_req = req;
    end
    while (!gnt) begin
      @(negedge clk);
      gnt = (host == CoreData) ? data_gnt : instr_gnt;
      @(posedge clk);
      #2;
    end
    data_req  = '0;
    instr_req = '0;
    @(negedge clk);
    rsp = (host == CoreData) ? data_rsp : instr_rsp;
  endtask

  task automatic bus_write(input bus_host_e host, input logic [31:0] addr,
                           input logic [31:0] wdata);
    bus_rsp_t rsp;
    bus_rsp_t exp;
    exp.rvalid = 1'b1;
    exp.err    = 1'b0;
    exp.rdata  = '0;
    bus_access(host, 1'b1, 4'hF, addr, wdata, rsp);
    check_rsp(rsp, exp, 1'b0, "word write");
    if ((addr & RamMask) == RamBase) begin
      model_write(addr, 4'hF, wdata);
    end
  endtask

  // Both core ports request in the same cycle
  task automatic dual_read(input logic [31:0] addr_d, input logic [31:0] addr_i);
    bus_host_e order [$];
    bus_rsp_t  exp_d;
    bus_rsp_t  exp_i;
    logic      d_wait;
    logic      i_wait;
    logic      d_due;
    logic      i_due;
    exp_d = {1'b1, 1'b0, model[addr_d[RamIdxWidth+1:2]]};
    exp_i = {1'b1, 1'b0, model[addr_i[RamIdxWidth+1:2]]};
    @(posedge clk);
    #2;
    data_req  = {1'b1, 1'b0, 4'hF, addr_d, 32'h0};
    instr_req = {1'b1, 1'b0, 4'hF, addr_i, 32'h0};
    d_wait = 1'b1;
    i_wait = 1'b1;
    d_due  = 1'b0;
    i_due  = 1'b0;
    while (d_wait || i_wait || d_due || i_due) begin
      @(negedge clk);
      if (d_due) begin
        check_rsp(data_rsp, exp_d, 1'b1, "dual data read");
      end
      if (i_due) begin
        check_rsp(instr_rsp, exp_i, 1'b1, "dual instr read");
      end
      d_due = d_wait && data_gnt;
      i_due = i_wait && instr_gnt;
      if (d_due && i_due) begin
        $display("Both hosts were granted in the same cycle");
        errors++;
      end
      if (d_due) begin
        order.push_back(CoreData);
        d_wait = 1'b0;
      end
      if (i_due) begin
        order.push_back(CoreInstr);
        i_wait = 1'b0;
      end
      @(posedge clk);
      #2;
      if (!d_wait) data_req = '0;
      if (!i_wait) instr_req = '0;
    end
    check_host(order[0], CoreData);
    check_host(order[1], CoreInstr);
  endtask

  // Words must follow the region in address order under random back-pressure
  task automatic collect_dump(input logic [31:0] base, input int nr_words);
    int                     got;
    logic                   halt_due;
    logic                   done;
    logic [RamIdxWidth-1:0] idx;
    got      = 0;
    halt_due = 1'b0;
    done     = 1'b0;
    while (!done) begin
      @(posedge clk);
      #2;
      dump_ready = ($random(seed) % 4) != 0;
      @(negedge clk);
      if (halt_due && !halted) begin
        $display("[ERROR] %0t: halted_o low one cycle after the last word", $time);
        errors++;
      end
      halt_due = 1'b0;
      if (halted) begin
        done = 1'b1;
      end else if (dump_valid && dump_ready) begin
        idx = base[RamIdxWidth+1:2] + got[RamIdxWidth-1:0];
        check_dump_word(dump, model[idx], got);
        got++;
        halt_due = (got == nr_words);
      end
    end
    @(posedge clk);
    #2;
    dump_ready = 1'b0;
    if (got != nr_words) begin
      $display("The stream delivered %0d words instead of %0d", got, nr_words);
      errors++;
    end
  endtask

  initial begin
    tbl_entry_t  e;
    bus_rsp_t    rsp;
    bus_rsp_t    exp;
    logic        ram_hit;
    logic [31:0] word;
    int          errs_before;
    data_req   = '0;
    instr_req  = '0;
    dump_ready = 1'b0;
    apply_reset();

    for (int i = 0; i < TableLen; i++) begin
      errs_before = errors;
      e           = tbl[i];
      ram_hit     = (e.addr & RamMask) == RamBase;
      exp.rvalid  = 1'b1;
      exp.err     = e.exp_err;
      exp.rdata   = ram_hit ? model[e.addr[RamIdxWidth+1:2]] : e.exp_rdata;
      bus_access(e.host, e.we, e.be, e.addr, e.wdata, rsp);
      check_rsp(rsp, exp, !e.we, $sformatf("entry %0d", i));
      if (ram_hit && e.we) begin
        model_write(e.addr, e.be, e.wdata);
      end
      report_test($sformatf("table entry %0d", i), errs_before);
    end

    errs_before = errors;
    dual_read(32'h0000_0100, 32'h0000_0104);
    report_test("simultaneous requests", errs_before);

    errs_before = errors;
    for (int k = 0; k < DumpWords; k++) begin
      word = $random(seed);
      bus_write(k[0] ? CoreInstr : CoreData, SigBase + 32'(4 * k), word);
    end
    bus_write(CoreData, RegBegin, SigBase);
    bus_write(CoreData, RegEnd, SigBase + 32'(4 * DumpWords));
    bus_write(CoreData, RegHalt, 32'h1);
    collect_dump(SigBase, DumpWords);
    report_test("signature dump", errs_before);

    // Dump runs once per reset
    errs_before = errors;
    apply_reset();
    bus_write(CoreData, RegBegin, EmptyBase);
    bus_write(CoreData, RegEnd, EmptyBase);
    bus_write(CoreData, RegHalt, 32'h1);
    collect_dump(EmptyBase, 0);
    report_test("empty region", errs_before);

    if (u_dut.u_assertions.nr_failures != 0) begin
      $display("Bus protocol assertions failed %0d time(s)", u_dut.u_assertions.nr_failures);
      errors += u_dut.u_assertions.nr_failures;
    end
    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: src.f
hdl/bus_pkg.sv
hdl/mem_map_pkg.sv
hdl/bus_arbiter.sv
hdl/bus_router.sv
hdl/ram_1p.sv
hdl/test_util.sv
hdl/compliance_top.sv
dv/compliance_assertions.sv
dv/tb_compliance.sv

// File: Makefile
# Verilator build and run for the compliance bus fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_compliance
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= FAIL: see errors above

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(SIM) > $(LOG) 2>&1 || echo "simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if grep -q "simulator exited with an error" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
